/* common/lane_settings.svh */
// Lane widths, engine count and FIFO depth settings
`ifndef LANE_SETTINGS_SVH
`define LANE_SETTINGS_SVH

// Engines sharing one memory port, id width must cover them
`define LANE_NUM_ENGINES 4
`define LANE_ID_W 2

// Packet field widths
`define LANE_ADDR_W 32
`define LANE_DATA_W 32
`define LANE_CNT_W 16

// Buffering on the shared request and response paths
`define LANE_REQ_FIFO_DEPTH 16
`define LANE_RSP_FIFO_DEPTH 16

// Free slots still open when prog_full rises
`define LANE_PROG_FULL_MARGIN 2

`endif

/* common/engine_pkg.sv */
// Engine FSM states and packet opcodes
`default_nettype none

package engine_pkg;

    // Engine run states
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        ISSUE,
        DRAIN,
        DONE
    } engine_state_e;

    // Read request to memory, data on the lane
    typedef enum logic [0:0] {
        OP_READ,
        OP_DATA
    } packet_opcode_e;

endpackage

`default_nettype wire

/* common/lane_pkg.sv */
// Packet, descriptor and FIFO handshake structs shared across the lane
`default_nettype none

`include "lane_settings.svh"

package lane_pkg;

    // One request, response or lane packet
    typedef struct packed {
        logic                           valid;
        engine_pkg::packet_opcode_e     opcode;
        logic [`LANE_ID_W-1:0]          id;
        logic [`LANE_ADDR_W-1:0]        addr;
        logic [`LANE_DATA_W-1:0]        data;
    } mem_packet_t;

    // Kernel start, one run of count reads per engine
    typedef struct packed {
        logic                           valid;
        logic [`LANE_ADDR_W-1:0]        base;
        logic [`LANE_CNT_W-1:0]         count;
    } descriptor_t;

    // Receiver to sender
    typedef struct packed {
        logic rd_en;
    } fifo_ctrl_in_t;

    // FIFO state seen by the other side
    typedef struct packed {
        logic empty;
        logic prog_full;
    } fifo_ctrl_out_t;

endpackage

`default_nettype wire

/* logic/fifo_sync.sv */
// Synchronous packet FIFO with registered output, empty and prog_full flags
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"

module fifo_sync #(
    parameter int DEPTH = 16
) (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_i,
    input  wire lane_pkg::mem_packet_t   wr_packet_i,
    input  wire lane_pkg::fifo_ctrl_in_t ctrl_i,
    output lane_pkg::mem_packet_t        rd_packet_o,
    output lane_pkg::fifo_ctrl_out_t     ctrl_o
);

    // DEPTH is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    lane_pkg::mem_packet_t mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok = wr_packet_i.valid && (count_q != CNT_W'(DEPTH));
    assign rd_ok = ctrl_i.rd_en && (count_q != '0);

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem_q[wr_ptr_q] <= wr_packet_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_i) begin
            wr_ptr_q          <= '0;
            rd_ptr_q          <= '0;
            count_q           <= '0;
            rd_packet_o.valid <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(wr_ok);
            rd_ptr_q <= rd_ptr_q + PTR_W'(rd_ok);
            count_q  <= count_q + CNT_W'(wr_ok) - CNT_W'(rd_ok);
            // Output register moves only on rd_en, otherwise the head stays put
            if (ctrl_i.rd_en) begin
                rd_packet_o       <= mem_q[rd_ptr_q];
                rd_packet_o.valid <= rd_ok;
            end
        end
    end

    // Empty also covers a packet still waiting in the output register
    assign ctrl_o.empty     = (count_q == '0) && !rd_packet_o.valid;
    // One slot beyond the margin for the write already in flight
    assign ctrl_o.prog_full = count_q >= CNT_W'(DEPTH - `LANE_PROG_FULL_MARGIN - 1);

endmodule

`default_nettype wire

/* arbiter/arbiter_n_to_1_request.sv */
// Round-robin merge of engine read requests into one request FIFO
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"

module arbiter_n_to_1_request (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_i,
    input  wire lane_pkg::mem_packet_t   request_i [`LANE_NUM_ENGINES],
    output logic [`LANE_NUM_ENGINES-1:0] grant_rd_en_o,
    input  wire lane_pkg::fifo_ctrl_in_t ctrl_i,
    output lane_pkg::mem_packet_t        request_o,
    output lane_pkg::fifo_ctrl_out_t     ctrl_o
);

    logic [`LANE_ID_W-1:0]    ptr_q;
    logic [`LANE_ID_W-1:0]    sel;
    logic                     sel_valid;
    logic                     fire;
    lane_pkg::mem_packet_t    wr_q;
    lane_pkg::fifo_ctrl_out_t fifo_ctrl;

    // ------------------------------------------------------------------------
    // Grant selection
    // ------------------------------------------------------------------------
    // First requesting engine at or after the rotating pointer
    always_comb begin
        logic [`LANE_ID_W-1:0] idx;
        sel       = '0;
        sel_valid = 1'b0;
        for (int k = 0; k < `LANE_NUM_ENGINES; k++) begin
            idx = ptr_q + `LANE_ID_W'(k);
            if (!sel_valid && request_i[idx].valid) begin
                sel       = idx;
                sel_valid = 1'b1;
            end
        end
    end

    // No grant while the FIFO is nearly full
    assign fire = sel_valid && !fifo_ctrl.prog_full;

    always_comb begin
        for (int k = 0; k < `LANE_NUM_ENGINES; k++) begin
            grant_rd_en_o[k] = fire && (sel == `LANE_ID_W'(k));
        end
    end

    // Granted packet lands in the FIFO one cycle later
    always_ff @(posedge ap_clk) begin
        if (areset_i) begin
            ptr_q      <= '0;
            wr_q.valid <= 1'b0;
        end else begin
            wr_q       <= request_i[sel];
            wr_q.valid <= fire;
            if (fire) begin
                ptr_q <= sel + 1'b1;
            end
        end
    end

    fifo_sync #(
        .DEPTH(`LANE_REQ_FIFO_DEPTH)
    ) u_req_fifo (
        .ap_clk     (ap_clk),
        .areset_i   (areset_i),
        .wr_packet_i(wr_q),
        .ctrl_i     (ctrl_i),
        .rd_packet_o(request_o),
        .ctrl_o     (fifo_ctrl)
    );

    assign ctrl_o.empty     = fifo_ctrl.empty && !wr_q.valid;
    assign ctrl_o.prog_full = fifo_ctrl.prog_full;

endmodule

`default_nettype wire

/* arbiter/arbiter_1_to_n_response.sv */
// Memory response FIFO with routing of each packet to the engine its id names
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"

module arbiter_1_to_n_response (
    input  wire logic                     ap_clk,
    input  wire logic                     areset_i,
    input  wire lane_pkg::mem_packet_t    response_i,
    input  wire lane_pkg::fifo_ctrl_out_t engine_ctrl_i [`LANE_NUM_ENGINES],
    output lane_pkg::mem_packet_t         response_o [`LANE_NUM_ENGINES],
    output lane_pkg::fifo_ctrl_out_t      ctrl_o
);

    lane_pkg::mem_packet_t  head;
    lane_pkg::fifo_ctrl_in_t head_ctrl;
    logic                   fwd;

    // Head leaves only when its engine has room
    assign fwd             = head.valid && !engine_ctrl_i[head.id].prog_full;
    // Refill the head when it is empty or leaving this cycle
    assign head_ctrl.rd_en = !head.valid || fwd;

    fifo_sync #(
        .DEPTH(`LANE_RSP_FIFO_DEPTH)
    ) u_rsp_fifo (
        .ap_clk     (ap_clk),
        .areset_i   (areset_i),
        .wr_packet_i(response_i),
        .ctrl_i     (head_ctrl),
        .rd_packet_o(head),
        .ctrl_o     (ctrl_o)
    );

    // One cycle from head to engine, valid only on the addressed port
    always_ff @(posedge ap_clk) begin
        if (areset_i) begin
            for (int k = 0; k < `LANE_NUM_ENGINES; k++) begin
                response_o[k].valid <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `LANE_NUM_ENGINES; k++) begin
                response_o[k]       <= head;
                response_o[k].valid <= fwd && (head.id == `LANE_ID_W'(k));
            end
        end
    end

endmodule

`default_nettype wire

/* engine/engine_template.sv */
// Per-engine read issue, response collection and lane forwarding FSM
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"

module engine_template #(
    parameter int ENGINE_ID = 0
) (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_i,
    input  wire lane_pkg::descriptor_t   descriptor_i,
    output lane_pkg::mem_packet_t        request_o,
    input  wire logic                    request_rd_en_i,
    input  wire lane_pkg::mem_packet_t   response_i,
    output lane_pkg::fifo_ctrl_out_t     response_ctrl_o,
    input  wire lane_pkg::mem_packet_t   lane_i,
    output lane_pkg::fifo_ctrl_out_t     lane_ctrl_o,
    output lane_pkg::mem_packet_t        lane_o,
    input  wire logic                    lane_rd_en_i,
    output logic                         done_o
);

    localparam logic [`LANE_ID_W-1:0] ID = `LANE_ID_W'(ENGINE_ID);

    engine_pkg::engine_state_e state_q;
    logic [`LANE_ADDR_W-1:0]   base_q;
    logic [`LANE_ADDR_W-1:0]   addr_q;
    logic [`LANE_CNT_W-1:0]    count_q;
    logic [`LANE_CNT_W-1:0]    issue_cnt_q;
    logic [`LANE_CNT_W-1:0]    rsp_cnt_q;
    lane_pkg::mem_packet_t     hold_q;
    lane_pkg::mem_packet_t     rsp_data;
    lane_pkg::mem_packet_t     own_pkt;
    lane_pkg::mem_packet_t     lane_wr;
    lane_pkg::fifo_ctrl_out_t  lane_ctrl;
    lane_pkg::fifo_ctrl_in_t   lane_rd;
    logic                      lane_take;

    // ------------------------------------------------------------------------
    // Run FSM and read issue
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_i) begin
            state_q         <= engine_pkg::IDLE;
            request_o.valid <= 1'b0;
            issue_cnt_q     <= '0;
            rsp_cnt_q       <= '0;
        end else begin
            // Slot frees once the arbiter took the packet
            if (request_rd_en_i) begin
                request_o.valid <= 1'b0;
            end
            if (response_i.valid) begin
                rsp_cnt_q <= rsp_cnt_q + 1'b1;
            end
            case (state_q)
                engine_pkg::IDLE, engine_pkg::DONE: begin
                    if (descriptor_i.valid) begin
                        base_q  <= descriptor_i.base;
                        count_q <= descriptor_i.count;
                        state_q <= engine_pkg::SETUP;
                    end
                end
                engine_pkg::SETUP: begin
                    // Interleaved start, this engine owns every Nth word
                    addr_q      <= base_q + `LANE_ADDR_W'(ENGINE_ID);
                    issue_cnt_q <= '0;
                    rsp_cnt_q   <= '0;
                    state_q     <= (count_q == '0) ? engine_pkg::DRAIN : engine_pkg::ISSUE;
                end
                engine_pkg::ISSUE: begin
                    if (!request_o.valid || request_rd_en_i) begin
                        request_o.valid  <= 1'b1;
                        request_o.opcode <= engine_pkg::OP_READ;
                        request_o.id     <= ID;
                        request_o.addr   <= addr_q;
                        request_o.data   <= '0;
                        addr_q           <= addr_q + `LANE_ADDR_W'(`LANE_NUM_ENGINES);
                        issue_cnt_q      <= issue_cnt_q + 1'b1;
                        if (issue_cnt_q + 1'b1 == count_q) begin
                            state_q <= engine_pkg::DRAIN;
                        end
                    end
                end
                engine_pkg::DRAIN: begin
                    if (rsp_cnt_q == count_q && !request_o.valid && !hold_q.valid &&
                        lane_ctrl.empty) begin
                        state_q <= engine_pkg::DONE;
                    end
                end
                default: state_q <= engine_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Lane merge, upstream packets first
    // ------------------------------------------------------------------------
    always_comb begin
        rsp_data        = response_i;
        rsp_data.opcode = engine_pkg::OP_DATA;
        rsp_data.id     = ID;
        own_pkt         = hold_q.valid ? hold_q : rsp_data;
        lane_take       = lane_i.valid && !lane_ctrl.prog_full;
        lane_wr         = lane_take ? lane_i : own_pkt;
    end

    // Own data parks here for a cycle when upstream wins the write
    always_ff @(posedge ap_clk) begin
        if (areset_i) begin
            hold_q.valid <= 1'b0;
        end else if (lane_take) begin
            hold_q <= own_pkt;
        end else begin
            hold_q.valid <= 1'b0;
        end
    end

    assign lane_rd.rd_en = lane_rd_en_i;

    fifo_sync #(
        .DEPTH(`LANE_RSP_FIFO_DEPTH)
    ) u_lane_fifo (
        .ap_clk     (ap_clk),
        .areset_i   (areset_i),
        .wr_packet_i(lane_wr),
        .ctrl_i     (lane_rd),
        .rd_packet_o(lane_o),
        .ctrl_o     (lane_ctrl)
    );

    assign lane_ctrl_o = lane_ctrl;
    // Incoming and parked responses both count against the router
    assign response_ctrl_o.empty     = lane_ctrl.empty && !hold_q.valid;
    assign response_ctrl_o.prog_full = lane_ctrl.prog_full || hold_q.valid || response_i.valid;

    assign done_o = (state_q == engine_pkg::DONE) && lane_ctrl.empty && !lane_take;

endmodule

`default_nettype wire

/* logic/lane_template.sv */
// Lane top level with registered ports, arbiters and the engine chain
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"

module lane_template (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_i,
    input  wire lane_pkg::descriptor_t   descriptor_i,
    input  wire lane_pkg::mem_packet_t   response_mem_i,
    output lane_pkg::fifo_ctrl_out_t     response_mem_ctrl_o,
    output lane_pkg::mem_packet_t        request_mem_o,
    input  wire lane_pkg::fifo_ctrl_in_t request_mem_rd_en_i,
    output lane_pkg::mem_packet_t        lane_out_o,
    input  wire lane_pkg::fifo_ctrl_in_t lane_out_rd_en_i,
    output logic                         done_o
);

    localparam int N = `LANE_NUM_ENGINES;

    logic                     areset_lane_template;
    lane_pkg::descriptor_t    descriptor_q;
    lane_pkg::mem_packet_t    response_q;
    lane_pkg::mem_packet_t    arb_req;
    lane_pkg::fifo_ctrl_out_t req_ctrl;
    lane_pkg::fifo_ctrl_out_t rsp_ctrl;
    lane_pkg::mem_packet_t    eng_req [N];
    lane_pkg::mem_packet_t    eng_rsp [N];
    lane_pkg::fifo_ctrl_out_t eng_rsp_ctrl [N];
    lane_pkg::mem_packet_t    eng_lane [N];
    lane_pkg::mem_packet_t    eng_lane_in [N];
    lane_pkg::fifo_ctrl_out_t eng_lane_ctrl [N];
    logic [N-1:0]             eng_lane_rd_en;
    logic [N-1:0]             grant;
    logic [N-1:0]             eng_done;

    // ------------------------------------------------------------------------
    // Reset and input registers
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_lane_template <= areset_i;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            descriptor_q.valid <= 1'b0;
            response_q.valid   <= 1'b0;
        end else begin
            descriptor_q <= descriptor_i;
            response_q   <= response_mem_i;
        end
    end

    // ------------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------------
    // Port rd_en enables the output stage directly, so a packet holds
    // until the far side took it and the FIFO behind pops in step
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            request_mem_o.valid           <= 1'b0;
            lane_out_o.valid              <= 1'b0;
            done_o                        <= 1'b0;
            response_mem_ctrl_o.empty     <= 1'b1;
            response_mem_ctrl_o.prog_full <= 1'b0;
        end else begin
            if (request_mem_rd_en_i.rd_en) begin
                request_mem_o <= arb_req;
            end
            if (lane_out_rd_en_i.rd_en) begin
                lane_out_o <= eng_lane[N-1];
            end
            response_mem_ctrl_o <= rsp_ctrl;
            // Nothing left anywhere, including the two output stages
            done_o <= (&eng_done) && req_ctrl.empty && rsp_ctrl.empty &&
                      !request_mem_o.valid && !lane_out_o.valid;
        end
    end

    arbiter_n_to_1_request u_req_arb (
        .ap_clk       (ap_clk),
        .areset_i     (areset_lane_template),
        .request_i    (eng_req),
        .grant_rd_en_o(grant),
        .ctrl_i       (request_mem_rd_en_i),
        .request_o    (arb_req),
        .ctrl_o       (req_ctrl)
    );

    arbiter_1_to_n_response u_rsp_arb (
        .ap_clk       (ap_clk),
        .areset_i     (areset_lane_template),
        .response_i   (response_q),
        .engine_ctrl_i(eng_rsp_ctrl),
        .response_o   (eng_rsp),
        .ctrl_o       (rsp_ctrl)
    );

    // ------------------------------------------------------------------------
    // Engine chain, in -> [0] -> [1] -> ... -> [N-1] -> lane_out_o
    // ------------------------------------------------------------------------
    for (genvar j = 0; j < N; j++) begin : g_engine
        if (j == 0) begin : g_first
            assign eng_lane_in[j] = '0;
        end else begin : g_link
            assign eng_lane_in[j] = eng_lane[j-1];
        end
        if (j == N - 1) begin : g_last
            assign eng_lane_rd_en[j] = lane_out_rd_en_i.rd_en;
        end else begin : g_mid
            assign eng_lane_rd_en[j] = !eng_lane_ctrl[j+1].prog_full;
        end

        engine_template #(
            .ENGINE_ID(j)
        ) u_engine (
            .ap_clk         (ap_clk),
            .areset_i       (areset_lane_template),
            .descriptor_i   (descriptor_q),
            .request_o      (eng_req[j]),
            .request_rd_en_i(grant[j]),
            .response_i     (eng_rsp[j]),
            .response_ctrl_o(eng_rsp_ctrl[j]),
            .lane_i         (eng_lane_in[j]),
            .lane_ctrl_o    (eng_lane_ctrl[j]),
            .lane_o         (eng_lane[j]),
            .lane_rd_en_i   (eng_lane_rd_en[j]),
            .done_o         (eng_done[j])
        );
    end

endmodule

`default_nettype wire

/* sim/lane_tb_settings.svh */
// Testbench memory data key and random seed
`ifndef LANE_TB_SETTINGS_SVH
`define LANE_TB_SETTINGS_SVH

// Memory model returns address XOR this key as read data
`define LANE_TB_DATA_KEY 32'hA5C3_1E79

// Seed for every random draw in the testbench
`define LANE_TB_SEED 21

`endif

/* sim/lane_template_assertions.sv */
// Bound concurrent checks on lane requests, lane output, hold behavior and reset
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"
`include "lane_tb_settings.svh"

module lane_template_assertions (
    input wire logic                     ap_clk,
    input wire logic                     areset_lane_template,
    input wire lane_pkg::descriptor_t    descriptor_i,
    input wire lane_pkg::fifo_ctrl_out_t response_mem_ctrl_o,
    input wire lane_pkg::mem_packet_t    request_mem_o,
    input wire lane_pkg::fifo_ctrl_in_t  request_mem_rd_en_i,
    input wire lane_pkg::mem_packet_t    lane_out_o,
    input wire lane_pkg::fifo_ctrl_in_t  lane_out_rd_en_i,
    input wire logic                     done_o
);

    int unsigned             fail_count = 0;
    logic [`LANE_ADDR_W-1:0] base_q;
    logic [`LANE_ADDR_W-1:0] span_q;
    logic [`LANE_ADDR_W-1:0] offset;

    // Run window latched from the descriptor port
    always_ff @(posedge ap_clk) begin
        if (descriptor_i.valid) begin
            base_q <= descriptor_i.base;
            span_q <= `LANE_ADDR_W'(descriptor_i.count) * `LANE_ADDR_W'(`LANE_NUM_ENGINES);
        end
    end

    // Position of the request inside the run
    assign offset = request_mem_o.addr - base_q;

    // -------------------------------------------------------------------------
    // Request stream
    // -------------------------------------------------------------------------
    // Read inside the run window with the id of its interleave position
    a_request_in_run: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        request_mem_o.valid |-> request_mem_o.opcode == engine_pkg::OP_READ &&
            offset < span_q &&
            request_mem_o.id == `LANE_ID_W'(offset % `LANE_ADDR_W'(`LANE_NUM_ENGINES)))
    else begin
        $error("request_mem_o has a wrong opcode, address or id");
        fail_count++;
    end

    // Stalled request keeps its packet
    a_request_hold: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        !$past(request_mem_rd_en_i.rd_en) && $past(request_mem_o.valid) |->
            request_mem_o == $past(request_mem_o))
    else begin
        $error("request_mem_o changed while request_mem_rd_en_i was low");
        fail_count++;
    end

    // -------------------------------------------------------------------------
    // Lane output
    // -------------------------------------------------------------------------
    // Data packets carry the memory pattern for their address
    a_lane_data: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        lane_out_o.valid |-> lane_out_o.opcode == engine_pkg::OP_DATA &&
            lane_out_o.data == (lane_out_o.addr ^ `LANE_TB_DATA_KEY))
    else begin
        $error("lane_out_o has a wrong opcode or data");
        fail_count++;
    end

    // Stalled lane packet stays on the port
    a_lane_hold: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        !$past(lane_out_rd_en_i.rd_en) && $past(lane_out_o.valid) |->
            lane_out_o == $past(lane_out_o))
    else begin
        $error("lane_out_o changed while lane_out_rd_en_i was low");
        fail_count++;
    end

    // Outputs quiet and response flags idle right after a reset cycle
    a_reset_quiet: assert property (@(posedge ap_clk)
        areset_lane_template |=> !request_mem_o.valid && !lane_out_o.valid && !done_o &&
            response_mem_ctrl_o.empty && !response_mem_ctrl_o.prog_full)
    else begin
        $error("outputs not cleared after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

/* sim/lane_template_tb.sv */
// Lane testbench with clock, reset, descriptor runs, memory model, lane sink and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "lane_settings.svh"
`include "lane_tb_settings.svh"

module lane_template_tb;

    localparam int N               = `LANE_NUM_ENGINES;
    localparam int COUNT_FIRST     = 5;
    localparam int COUNT_SECOND    = 12;
    localparam int MAX_MEM_DELAY   = 8;
    // Cycle bound per read covering memory delay and sink stalls
    localparam int CYCLES_PER_READ = 40;
    localparam int CYCLE_LIMIT     = 100 + (COUNT_FIRST + COUNT_SECOND) * N * CYCLES_PER_READ;

    logic                     ap_clk;
    logic                     areset_i            = 1'b1;
    lane_pkg::descriptor_t    descriptor_i        = '0;
    lane_pkg::mem_packet_t    response_mem_i      = '0;
    lane_pkg::fifo_ctrl_out_t response_mem_ctrl_o;
    lane_pkg::mem_packet_t    request_mem_o;
    lane_pkg::fifo_ctrl_in_t  request_mem_rd_en_i = '0;
    lane_pkg::mem_packet_t    lane_out_o;
    lane_pkg::fifo_ctrl_in_t  lane_out_rd_en_i    = '0;
    logic                     done_o;

    int                       seed        = `LANE_TB_SEED;
    int                       error_count = 0;
    int                       cycle_count = 0;
    int                       lane_total  = 0;
    logic [`LANE_ADDR_W-1:0]  run_base    = '0;
    logic [`LANE_ADDR_W-1:0]  run_span    = '0;
    bit                       seen [logic [`LANE_ADDR_W-1:0]];
    // Memory replies waiting for their due cycle in request order
    lane_pkg::mem_packet_t    pend_pkt [$];
    int                       pend_due [$];

    lane_template dut (
        .ap_clk             (ap_clk),
        .areset_i           (areset_i),
        .descriptor_i       (descriptor_i),
        .response_mem_i     (response_mem_i),
        .response_mem_ctrl_o(response_mem_ctrl_o),
        .request_mem_o      (request_mem_o),
        .request_mem_rd_en_i(request_mem_rd_en_i),
        .lane_out_o         (lane_out_o),
        .lane_out_rd_en_i   (lane_out_rd_en_i),
        .done_o             (done_o)
    );

    bind lane_template lane_template_assertions u_assertions (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .descriptor_i        (descriptor_i),
        .response_mem_ctrl_o (response_mem_ctrl_o),
        .request_mem_o       (request_mem_o),
        .request_mem_rd_en_i (request_mem_rd_en_i),
        .lane_out_o          (lane_out_o),
        .lane_out_rd_en_i    (lane_out_rd_en_i),
        .done_o              (done_o)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout, the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // -------------------------------------------------------------------------
    // Memory model and sink ready drawn from one random stream
    // -------------------------------------------------------------------------
    always @(posedge ap_clk) begin : memory_model
        lane_pkg::mem_packet_t rsp;
        if (areset_i) begin
            request_mem_rd_en_i <= '0;
            lane_out_rd_en_i    <= '0;
            response_mem_i      <= '0;
        end else begin
            // Packet leaves request_mem_o on an edge that sees rd_en high
            if (request_mem_o.valid && request_mem_rd_en_i.rd_en) begin
                rsp        = request_mem_o;
                rsp.opcode = engine_pkg::OP_DATA;
                rsp.data   = request_mem_o.addr ^ `LANE_TB_DATA_KEY;
                pend_pkt.push_back(rsp);
                pend_due.push_back(cycle_count + 1 +
                                   int'($unsigned($random(seed)) % MAX_MEM_DELAY));
            end
            // No new reply while the response FIFO is nearly full
            if (pend_pkt.size() != 0 && pend_due[0] <= cycle_count &&
                !response_mem_ctrl_o.prog_full) begin
                response_mem_i <= pend_pkt.pop_front();
                void'(pend_due.pop_front());
            end else begin
                response_mem_i.valid <= 1'b0;
            end
            request_mem_rd_en_i.rd_en <= ($random(seed) % 4) != 0;
            lane_out_rd_en_i.rd_en    <= ($random(seed) % 2) != 0;
        end
    end

    // Lane sink expects every address of a run exactly once
    always @(posedge ap_clk) begin : lane_sink
        logic [`LANE_ADDR_W-1:0] offset;
        if (!areset_i && lane_out_o.valid && lane_out_rd_en_i.rd_en) begin
            offset      = lane_out_o.addr - run_base;
            lane_total <= lane_total + 1;
            if (offset >= run_span) begin
                $display("[ERROR] lane_out_o.addr 0x%08h outside base 0x%08h span 0x%0h",
                         lane_out_o.addr, run_base, run_span);
                error_count++;
            end
            if (seen.exists(lane_out_o.addr)) begin
                $display("[ERROR] lane_out_o.addr 0x%08h received twice", lane_out_o.addr);
                error_count++;
            end else begin
                seen[lane_out_o.addr] = 1'b1;
            end
        end
    end

    // One descriptor pulse followed by a wait for done_o
    task automatic run_descriptor(input logic [`LANE_ADDR_W-1:0] base, input int count);
        int start_total;
        int expected;
        start_total = lane_total;
        expected    = count * N;
        run_base    = base;
        run_span    = `LANE_ADDR_W'(expected);
        @(posedge ap_clk);
        descriptor_i.base  <= base;
        descriptor_i.count <= `LANE_CNT_W'(count);
        descriptor_i.valid <= 1'b1;
        @(posedge ap_clk);
        descriptor_i.valid <= 1'b0;
        // Done of the previous run clears a few cycles after the pulse
        while (done_o) @(posedge ap_clk);
        while (!done_o) @(posedge ap_clk);
        if (lane_total - start_total != expected) begin
            $display("done_o rose after %0d of %0d lane packets",
                     lane_total - start_total, expected);
            error_count++;
        end
        // Late extra packets would land here
        repeat (8) @(posedge ap_clk);
        if (lane_total - start_total != expected) begin
            $display("[ERROR] lane_out_o packet count got 0x%0h expected 0x%0h",
                     lane_total - start_total, expected);
            error_count++;
        end
    endtask

    initial begin : main
        repeat (2) @(posedge ap_clk);
        areset_i <= 1'b0;
        // Internal reset register trails the port by one cycle
        repeat (3) @(posedge ap_clk);
        run_descriptor(32'h0000_1000, COUNT_FIRST);
        run_descriptor(32'h0002_0040, COUNT_SECOND);
        $display("Lane packets %0d, testbench errors %0d, assertion failures %0d",
                 lane_total, error_count, dut.u_assertions.fail_count);
        if (error_count == 0 && dut.u_assertions.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+sim
common/engine_pkg.sv
common/lane_pkg.sv
logic/fifo_sync.sv
arbiter/arbiter_n_to_1_request.sv
arbiter/arbiter_1_to_n_response.sv
engine/engine_template.sv
logic/lane_template.sv
sim/lane_template_assertions.sv
sim/lane_template_tb.sv

/* Makefile */
TOP := lane_template_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
